// File: collision_judge.sv
// Player versus ghost collision check
`default_nettype none
`timescale 1ns/1ps

module collision_judge import maze_pkg::*; (
    input  wire          clock,
    input  wire          resetn,
    input  wire grid_x_t player_x,
    input  wire grid_x_t ghost1_x,
    input  wire grid_x_t ghost2_x,
    input  wire grid_x_t ghost3_x,
    input  wire grid_y_t player_y,
    input  wire grid_y_t ghost1_y,
    input  wire grid_y_t ghost2_y,
    input  wire grid_y_t ghost3_y,
    input  wire          step_pending,  // Raw step from outside
    output logic         step_done,     // One pulse per accepted step
    output logic         collided,      // Valid with step_done
    output logic         game_over      // Sticky until reset
);

    logic step_q;   // Step accepted last cycle, positions now settled
    logic hit;      // Player shares a cell with some ghost

    assign hit = ((player_x == ghost1_x) && (player_y == ghost1_y))
              || ((player_x == ghost2_x) && (player_y == ghost2_y))
              || ((player_x == ghost3_x) && (player_y == ghost3_y));

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            step_q    <= 1'b0;
            step_done <= 1'b0;
            collided  <= 1'b0;
            game_over <= 1'b0;
        end else begin
            step_q    <= step_pending && !game_over; // Same gate as the movers
            step_done <= step_q;
            collided  <= step_q && hit;
            if (step_q && hit) begin
                game_over <= 1'b1; // First collision latches
            end
        end
    end

    // Back-to-back done only from back-to-back requests
    done_spacing: assert property (@(posedge clock) disable iff (!resetn)
        (step_done && $past(step_done))
            |-> ($past(step_pending, 2) && $past(step_pending, 3)));

endmodule

`default_nettype wire

// File: game_step_top.sv
// Maze chase game step core
`default_nettype none
`timescale 1ns/1ps

module game_step_top import maze_pkg::*; #(
    parameter int GHOST1_BASE = 0,     // Path 1 starts at (3,3)
    parameter int GHOST1_LEN  = 16,
    parameter int GHOST2_BASE = 16,    // Path 2 starts at (6,6)
    parameter int GHOST2_LEN  = 20,
    parameter int GHOST3_BASE = 36,    // Path 3 starts at (8,8)
    parameter int GHOST3_LEN  = 12
) (
    input  wire       clock,
    input  wire       resetn,
    input  wire       step,         // One-cycle step request
    input  wire dir_t dir,          // Player direction for this step
    output grid_x_t   player_x,
    output grid_y_t   player_y,
    output grid_x_t   ghost1_x,
    output grid_x_t   ghost2_x,
    output grid_x_t   ghost3_x,
    output grid_y_t   ghost1_y,
    output grid_y_t   ghost2_y,
    output grid_y_t   ghost3_y,
    output logic      step_done,    // Two cycles after step
    output logic      collided,
    output logic      game_over     // Also freezes both movers
);

    player_mover u_player (
        .clock    (clock),
        .resetn   (resetn),
        .step     (step),
        .frozen   (game_over),
        .dir      (dir),
        .player_x (player_x),
        .player_y (player_y)
    );

    ghost_bank #(
        .GHOST1_BASE (GHOST1_BASE),
        .GHOST1_LEN  (GHOST1_LEN),
        .GHOST2_BASE (GHOST2_BASE),
        .GHOST2_LEN  (GHOST2_LEN),
        .GHOST3_BASE (GHOST3_BASE),
        .GHOST3_LEN  (GHOST3_LEN)
    ) u_ghosts (
        .clock    (clock),
        .resetn   (resetn),
        .step     (step),
        .frozen   (game_over),
        .ghost1_x (ghost1_x),
        .ghost1_y (ghost1_y),
        .ghost2_x (ghost2_x),
        .ghost2_y (ghost2_y),
        .ghost3_x (ghost3_x),
        .ghost3_y (ghost3_y)
    );

    // Judges positions one cycle after each move
    collision_judge u_judge (
        .clock        (clock),
        .resetn       (resetn),
        .player_x     (player_x),
        .ghost1_x     (ghost1_x),
        .ghost2_x     (ghost2_x),
        .ghost3_x     (ghost3_x),
        .player_y     (player_y),
        .ghost1_y     (ghost1_y),
        .ghost2_y     (ghost2_y),
        .ghost3_y     (ghost3_y),
        .step_pending (step),
        .step_done    (step_done),
        .collided     (collided),
        .game_over    (game_over)
    );

endmodule

`default_nettype wire

// File: game_trace.txt
# step dir player_x player_y g1_x g1_y g2_x g2_y g3_x g3_y collided game_over
# dir: 1 up, 2 left, 3 down, 4 right, other stay; step 0 on a later line is a frozen step
0 0 1 1 3 3 6 6 8 8 0 0
1 1 1 0 4 3 7 6 9 8 0 0
1 1 1 0 5 3 8 6 10 8 0 0
1 2 0 0 6 3 9 6 11 8 0 0
1 2 0 0 7 3 10 6 11 9 0 0
1 0 0 0 7 4 11 6 11 10 0 0
1 5 0 0 7 5 12 6 11 11 0 0
1 6 0 0 7 6 12 7 10 11 0 0
1 7 0 0 7 7 12 8 9 11 0 0
1 0 0 0 6 7 12 9 8 11 0 0
1 7 0 0 5 7 12 10 8 10 0 0
1 4 1 0 4 7 11 10 8 9 0 0
1 4 2 0 3 7 10 10 8 8 0 0
1 4 3 0 3 6 9 10 9 8 0 0
1 4 4 0 3 5 8 10 10 8 0 0
1 4 5 0 3 4 7 10 11 8 0 0
1 4 6 0 3 3 6 10 11 9 0 0
1 4 7 0 4 3 6 9 11 10 0 0
1 4 8 0 5 3 6 8 11 11 0 0
1 4 9 0 6 3 6 7 10 11 0 0
1 4 10 0 7 3 6 6 9 11 0 0
1 4 11 0 7 4 7 6 8 11 0 0
1 4 12 0 7 5 8 6 8 10 0 0
1 4 13 0 7 6 9 6 8 9 0 0
1 4 14 0 7 7 10 6 8 8 0 0
1 4 15 0 6 7 11 6 9 8 0 0
1 4 16 0 5 7 12 6 10 8 0 0
1 4 17 0 4 7 12 7 11 8 0 0
1 4 18 0 3 7 12 8 11 9 0 0
1 4 19 0 3 6 12 9 11 10 0 0
1 4 20 0 3 5 12 10 11 11 0 0
1 4 21 0 3 4 11 10 10 11 0 0
1 4 22 0 3 3 10 10 9 11 0 0
1 4 23 0 4 3 9 10 8 11 0 0
1 4 24 0 5 3 8 10 8 10 0 0
1 4 25 0 6 3 7 10 8 9 0 0
1 4 26 0 7 3 6 10 8 8 0 0
1 4 27 0 7 4 6 9 9 8 0 0
1 4 28 0 7 5 6 8 10 8 0 0
1 4 28 0 7 6 6 7 11 8 0 0
1 3 28 1 7 7 6 6 11 9 0 0
1 3 28 2 6 7 7 6 11 10 0 0
1 3 28 3 5 7 8 6 11 11 0 0
1 3 28 4 4 7 9 6 10 11 0 0
1 3 28 5 3 7 10 6 9 11 0 0
1 3 28 6 3 6 11 6 8 11 0 0
1 3 28 7 3 5 12 6 8 10 0 0
1 3 28 8 3 4 12 7 8 9 0 0
1 3 28 9 3 3 12 8 8 8 0 0
1 3 28 10 4 3 12 9 9 8 0 0
1 3 28 11 5 3 12 10 10 8 0 0
1 3 28 12 6 3 11 10 11 8 0 0
1 3 28 12 7 3 10 10 11 9 0 0
1 2 27 12 7 4 9 10 11 10 0 0
1 2 26 12 7 5 8 10 11 11 0 0
1 2 25 12 7 6 7 10 10 11 0 0
1 2 24 12 7 7 6 10 9 11 0 0
1 2 23 12 6 7 6 9 8 11 0 0
1 2 22 12 5 7 6 8 8 10 0 0
1 2 21 12 4 7 6 7 8 9 0 0
1 2 20 12 3 7 6 6 8 8 0 0
1 2 19 12 3 6 7 6 9 8 0 0
1 2 18 12 3 5 8 6 10 8 0 0
1 2 17 12 3 4 9 6 11 8 0 0
1 2 16 12 3 3 10 6 11 9 0 0
1 2 15 12 4 3 11 6 11 10 0 0
1 2 14 12 5 3 12 6 11 11 0 0
1 2 13 12 6 3 12 7 10 11 0 0
1 2 12 12 7 3 12 8 9 11 0 0
1 1 12 11 7 4 12 9 8 11 0 0
1 1 12 10 7 5 12 10 8 10 1 1
0 4 12 10 7 5 12 10 8 10 0 1
0 1 12 10 7 5 12 10 8 10 0 1

// File: ghost_bank.sv
// Three-ghost path bank
`default_nettype none
`timescale 1ns/1ps

module ghost_bank import maze_pkg::*; #(
    parameter int GHOST1_BASE = 0,
    parameter int GHOST1_LEN  = 16,
    parameter int GHOST2_BASE = 16,
    parameter int GHOST2_LEN  = 20,
    parameter int GHOST3_BASE = 36,
    parameter int GHOST3_LEN  = 12
) (
    input  wire     clock,
    input  wire     resetn,
    input  wire     step,       // Shared advance request
    input  wire     frozen,     // Halts every ghost
    output grid_x_t ghost1_x,
    output grid_y_t ghost1_y,
    output grid_x_t ghost2_x,
    output grid_y_t ghost2_y,
    output grid_x_t ghost3_x,
    output grid_y_t ghost3_y
);

    // Each ghost owns its own stretch of the table
    ghost_walker #(.PATH_BASE(GHOST1_BASE), .PATH_LEN(GHOST1_LEN)) u_ghost1 (
        .clock   (clock),
        .resetn  (resetn),
        .step    (step),
        .frozen  (frozen),
        .ghost_x (ghost1_x),
        .ghost_y (ghost1_y)
    );

    ghost_walker #(.PATH_BASE(GHOST2_BASE), .PATH_LEN(GHOST2_LEN)) u_ghost2 (
        .clock   (clock),
        .resetn  (resetn),
        .step    (step),
        .frozen  (frozen),
        .ghost_x (ghost2_x),
        .ghost_y (ghost2_y)
    );

    ghost_walker #(.PATH_BASE(GHOST3_BASE), .PATH_LEN(GHOST3_LEN)) u_ghost3 (
        .clock   (clock),
        .resetn  (resetn),
        .step    (step),
        .frozen  (frozen),
        .ghost_x (ghost3_x),
        .ghost_y (ghost3_y)
    );

endmodule

`default_nettype wire

// File: ghost_paths.mem
// One entry per line, x in bits 8..4, y in bits 3..0 (ghost 1, ghost 2, ghost 3)
033
043
053
063
073
074
075
076
077
067
057
047
037
036
035
034
066
076
086
096
0a6
0b6
0c6
0c7
0c8
0c9
0ca
0ba
0aa
09a
08a
07a
06a
069
068
067
088
098
0a8
0b8
0b9
0ba
0bb
0ab
09b
08b
08a
089

// File: ghost_walker.sv
// Single ghost path follower
`default_nettype none
`timescale 1ns/1ps

module ghost_walker import maze_pkg::*; #(
    parameter int PATH_BASE = 0,    // First table line of this path
    parameter int PATH_LEN  = 16    // Entries before wrap
) (
    input  wire     clock,
    input  wire     resetn,
    input  wire     step,
    input  wire     frozen,
    output grid_x_t ghost_x,
    output grid_y_t ghost_y
);

    localparam logic [PATH_ADDR_W-1:0] BASE_ADDR = PATH_ADDR_W'(PATH_BASE);
    localparam logic [PATH_ADDR_W-1:0] LAST_IDX  = PATH_ADDR_W'(PATH_LEN - 1);

    path_entry_t            path_rom [0:PATH_DEPTH-1]; // Whole table, own copy
    logic [PATH_ADDR_W-1:0] path_idx;                  // Entry within this path
    logic [PATH_ADDR_W-1:0] next_idx;
    logic [PATH_ADDR_W-1:0] next_addr;
    path_entry_t            ghost_pos;
    logic                   accept;

    initial begin
        $readmemh(PATH_FILE, path_rom);
    end

    assign accept = step && !frozen;

    // Loop back to the first entry after the last
    assign next_idx  = (path_idx == LAST_IDX) ? '0 : path_idx + 1'b1;
    assign next_addr = BASE_ADDR + next_idx;

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            path_idx  <= '0;
            ghost_pos <= path_rom[BASE_ADDR]; // Start cell of the path
        end else if (accept) begin
            path_idx  <= next_idx;
            ghost_pos <= path_rom[next_addr];
        end
    end

    // Unpack table line
    assign ghost_x = ghost_pos.x;
    assign ghost_y = ghost_pos.y;

    // Index stays inside its own path
    idx_in_path: assert property (@(posedge clock) disable iff (!resetn)
        int'(path_idx) < PATH_LEN);

    // Path must not run off the table
    path_fits: assert property (@(posedge clock)
        (PATH_BASE + PATH_LEN) <= PATH_DEPTH);

endmodule

`default_nettype wire

// File: maze_pkg.sv
// Maze chase shared definitions
`default_nettype none

package maze_pkg;

    // Playfield size in cells
    localparam int GRID_W = 29;
    localparam int GRID_H = 13;

    typedef logic [4:0] grid_x_t; // Column 0..28
    typedef logic [3:0] grid_y_t; // Row 0..12

    // Direction codes, anything else is a stay
    typedef logic [2:0] dir_t;
    localparam dir_t DIR_UP    = 3'd1;
    localparam dir_t DIR_LEFT  = 3'd2;
    localparam dir_t DIR_DOWN  = 3'd3;
    localparam dir_t DIR_RIGHT = 3'd4;

    // Player cell after reset
    localparam grid_x_t PLAYER_START_X = 5'd1;
    localparam grid_y_t PLAYER_START_Y = 4'd1;

    // Ghost path table
    localparam int    PATH_ADDR_W = 6;
    localparam int    PATH_DEPTH  = 1 << PATH_ADDR_W; // 64 lines
    localparam string PATH_FILE   = "ghost_paths.mem";

    // One table line, x in the upper bits
    typedef struct packed {
        grid_x_t x;
        grid_y_t y;
    } path_entry_t;

endpackage

`default_nettype wire

// File: player_mover.sv
// Player position stepper
`default_nettype none
`timescale 1ns/1ps

module player_mover import maze_pkg::*; (
    input  wire       clock,
    input  wire       resetn,
    input  wire       step,     // One-cycle move request
    input  wire       frozen,   // Game over from the judge
    input  wire dir_t dir,      // Requested direction
    output grid_x_t   player_x,
    output grid_y_t   player_y
);

    localparam grid_x_t LAST_COL = grid_x_t'(GRID_W - 1);
    localparam grid_y_t LAST_ROW = grid_y_t'(GRID_H - 1);

    logic    accept;    // Step taken this cycle
    grid_x_t next_x;
    grid_y_t next_y;

    assign accept = step && !frozen;

    // Candidate cell with edge refusal
    always_comb begin
        next_x = player_x;
        next_y = player_y;
        case (dir)
            DIR_UP: begin
                if (player_y != '0) begin
                    next_y = player_y - 1'b1;
                end
            end
            DIR_DOWN: begin
                if (player_y != LAST_ROW) begin
                    next_y = player_y + 1'b1;
                end
            end
            DIR_LEFT: begin
                if (player_x != '0) begin
                    next_x = player_x - 1'b1;
                end
            end
            DIR_RIGHT: begin
                if (player_x != LAST_COL) begin
                    next_x = player_x + 1'b1;
                end
            end
            default: begin
                // Stay codes keep the cell
            end
        endcase
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            player_x <= PLAYER_START_X; // Top left corridor
            player_y <= PLAYER_START_Y;
        end else if (accept) begin
            player_x <= next_x;
            player_y <= next_y;
        end
    end

    // Position never leaves the playfield
    player_in_grid: assert property (@(posedge clock) disable iff (!resetn)
        (int'(player_x) < GRID_W) && (int'(player_y) < GRID_H));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the game step testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_game_step -f src.f -o tb_game_step_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/tb_game_step_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0

// File: src.f
maze_pkg.sv
player_mover.sv
ghost_walker.sv
ghost_bank.sv
collision_judge.sv
game_step_top.sv
tb_game_step.sv

// File: tb_game_step.sv
// Game step core testbench
`default_nettype none
`timescale 1ns/1ps

module tb_game_step import maze_pkg::*; ();

    localparam int COLS         = 12;  // Fields per trace line
    localparam int RESET_CYCLES = 8;
    localparam int DONE_WAIT    = 6;   // Cycles allowed for step_done
    localparam int FROZEN_WAIT  = 4;
    localparam int DRIVE_DELAY  = 10;  // ns after the rising edge

    logic    clock;
    logic    resetn;
    logic    step;
    dir_t    dir;
    grid_x_t player_x;
    grid_y_t player_y;
    grid_x_t ghost1_x;
    grid_x_t ghost2_x;
    grid_x_t ghost3_x;
    grid_y_t ghost1_y;
    grid_y_t ghost2_y;
    grid_y_t ghost3_y;
    logic    step_done;
    logic    collided;
    logic    game_over;

    int trace_q[$];     // Flat trace of COLS values per line
    int rows;
    int limit;          // Cycle budget, set once the trace is loaded
    int cycles;

    game_step_top uut (
        .clock     (clock),
        .resetn    (resetn),
        .step      (step),
        .dir       (dir),
        .player_x  (player_x),
        .player_y  (player_y),
        .ghost1_x  (ghost1_x),
        .ghost2_x  (ghost2_x),
        .ghost3_x  (ghost3_x),
        .ghost1_y  (ghost1_y),
        .ghost2_y  (ghost2_y),
        .ghost3_y  (ghost3_y),
        .step_done (step_done),
        .collided  (collided),
        .game_over (game_over)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock; // 100 ns period
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
            abort_run();
        end
    endtask

    function automatic int field(input int row, input int col);
        return trace_q[row * COLS + col];
    endfunction

    // All outputs against one trace line
    task automatic check_outputs(input int row);
        check_value("player_x", 32'(player_x), field(row, 2));
        check_value("player_y", 32'(player_y), field(row, 3));
        check_value("ghost1_x", 32'(ghost1_x), field(row, 4));
        check_value("ghost1_y", 32'(ghost1_y), field(row, 5));
        check_value("ghost2_x", 32'(ghost2_x), field(row, 6));
        check_value("ghost2_y", 32'(ghost2_y), field(row, 7));
        check_value("ghost3_x", 32'(ghost3_x), field(row, 8));
        check_value("ghost3_y", 32'(ghost3_y), field(row, 9));
        check_value("collided", 32'(collided), field(row, 10));
        check_value("game_over", 32'(game_over), field(row, 11));
    endtask

    task automatic load_trace();
        int    fd;
        int    code;
        string line;
        int    v[COLS];
        fd = $fopen("game_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open game_trace.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.getc(0) != "#") begin // Skip comment lines
                code = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
                               v[0], v[1], v[2], v[3], v[4], v[5],
                               v[6], v[7], v[8], v[9], v[10], v[11]);
                if (code == COLS) begin
                    foreach (v[i]) trace_q.push_back(v[i]);
                end
            end
        end
        $fclose(fd);
        rows = trace_q.size() / COLS;
        if (rows < 2) begin
            $display("trace file holds too few lines");
            abort_run();
        end
    endtask

    // One accepted step and its done pulse
    task automatic run_step(input int row);
        int waited;
        dir  = dir_t'(field(row, 1));
        step = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        step   = 1'b0;
        dir    = '0;
        check_value("step_done", 32'(step_done), 32'd0); // Judge still a cycle behind
        waited = 0;
        while (!step_done && waited < DONE_WAIT) begin
            @(posedge clock);
            #DRIVE_DELAY;
            waited++;
        end
        if (!step_done) begin
            $display("no step_done after the step of trace line %0d", row);
            abort_run();
        end
        if (waited != 1) begin
            $display("step_done came %0d cycles after the accepting edge instead of 1",
                     waited);
            abort_run();
        end
        check_outputs(row);
    endtask

    // Frozen step must get no response
    task automatic run_frozen_step(input int row);
        logic seen_done;
        if (!game_over) begin
            $display("trace line %0d expects game over but it is not set", row);
            abort_run();
        end
        dir  = dir_t'(field(row, 1));
        step = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        step      = 1'b0;
        dir       = '0;
        seen_done = step_done;
        for (int i = 0; i < FROZEN_WAIT; i++) begin
            @(posedge clock);
            #DRIVE_DELAY;
            seen_done = seen_done | step_done;
        end
        if (seen_done) begin
            $display("step_done came for a step during game over, line %0d", row);
            abort_run();
        end
        check_outputs(row);
    endtask

    // Cycle limit so the run cannot hang
    initial begin
        cycles = 0;
        wait (limit > 0);
        forever begin
            @(posedge clock);
            cycles++;
            if (cycles >= limit) begin
                $display("timeout after %0d cycles", cycles);
                abort_run();
            end
        end
    end

    initial begin
        resetn = 1'b0;
        step   = 1'b0;
        dir    = '0;
        limit  = 0;
        load_trace();
        limit = RESET_CYCLES + 8 * rows + 50;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        resetn = 1'b1;
        check_outputs(0); // Reset state before any step
        for (int r = 1; r < rows; r++) begin
            if (field(r, 0) != 0) begin
                run_step(r);
            end else begin
                run_frozen_step(r);
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
